//--- common/duel_pkg.sv
`default_nettype none

package duel_pkg;

	typedef logic [7:0] row_t;	// active low, bit 0 is the top row
	typedef logic [2:0] col_t;	// 0 is the left column
	typedef logic [3:0] life_t;
	typedef logic [3:0] ammo_t;

	typedef struct packed {
		row_t row;
		col_t col;
		logic guard;	// guard button as seen at the last tick
	} pos_t;

	// both bullets of one shot share a column
	typedef struct packed {
		row_t up_n;
		row_t down_n;
		col_t col;
	} shot_t;

	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire;
		logic guard;
	} btn_t;

	localparam row_t ROW_EMPTY = 8'b1111_1111;
	localparam life_t LIFE_FULL = 4'b1111;

	localparam pos_t A_START = '{row: 8'b0111_1111, col: 3'd4, guard: 1'b0};	// bottom row
	localparam pos_t B_START = '{row: 8'b1111_1110, col: 3'd4, guard: 1'b0};	// top row

	localparam int SCAN_SLOTS = 6;

endpackage

`default_nettype wire

//--- player/player_move.sv
`timescale 1ns/10ps
`default_nettype none

module player_move #(
	parameter duel_pkg::pos_t START = duel_pkg::A_START
) (
	input wire CLK,
	input wire Clear,
	input wire game_tick,
	input wire game_over,
	input wire duel_pkg::btn_t btn,
	output duel_pkg::pos_t pos
);

	import duel_pkg::*;

	always_ff @(posedge CLK or posedge Clear)
	begin
		if (Clear)
			pos <= START;
		else if (game_tick && !game_over)
		begin
			// up wins over down
			if (btn.up)
			begin
				if (pos.row[0])	// top row not lit yet
					pos.row <= {1'b1, pos.row[7:1]};
			end
			else if (btn.down)
			begin
				if (pos.row[7])
					pos.row <= {pos.row[6:0], 1'b1};
			end

			// left wins over right
			if (btn.left)
			begin
				if (pos.col != col_t'(0))
					pos.col <= pos.col - col_t'(1);
			end
			else if (btn.right)
			begin
				if (pos.col != col_t'(7))
					pos.col <= pos.col + col_t'(1);
			end

			pos.guard <= btn.guard;
		end
	end

	// the marker occupies exactly one row at all times
	a_row_single: assert property (@(posedge CLK) disable iff (Clear)
		$onehot(~pos.row))
		else $error("player_move: row mask %b does not hold one lit row", pos.row);

endmodule

`default_nettype wire

//--- player/player_shot.sv
`timescale 1ns/10ps
`default_nettype none

module player_shot #(
	parameter duel_pkg::ammo_t AMMO_INIT = 4'd9
) (
	input wire CLK,
	input wire Clear,
	input wire game_tick,
	input wire game_over,
	input wire fire,
	input wire duel_pkg::pos_t pos,
	output duel_pkg::shot_t shot,
	output duel_pkg::ammo_t ammo
);

	import duel_pkg::*;

	logic on_matrix;
	logic launch;

	assign on_matrix = (shot.up_n != ROW_EMPTY) || (shot.down_n != ROW_EMPTY);
	assign launch = !on_matrix && fire && (ammo != ammo_t'(0));

	always_ff @(posedge CLK or posedge Clear)
	begin
		if (Clear)
		begin
			shot <= '{up_n: ROW_EMPTY, down_n: ROW_EMPTY, col: col_t'(0)};
			ammo <= AMMO_INIT;
		end
		else if (game_tick && !game_over)
		begin
			if (launch)
			begin
				// a shooter on an edge row shifts its lit bit out, leaving that bullet empty
				shot.up_n <= {1'b1, pos.row[7:1]};
				shot.down_n <= {pos.row[6:0], 1'b1};
				shot.col <= pos.col;
				ammo <= ammo - ammo_t'(1);
			end
			else
			begin
				shot.up_n <= {1'b1, shot.up_n[7:1]};	// toward row 0
				shot.down_n <= {shot.down_n[6:0], 1'b1};	// toward row 7
			end
		end
	end

	a_ammo_no_rise: assert property (@(posedge CLK) disable iff (Clear)
		ammo <= $past(ammo))
		else $error("player_shot: ammo rose from %0d to %0d", $past(ammo), ammo);

	// a live bullet never splits into two rows or merges with another
	a_bullet_single: assert property (@(posedge CLK) disable iff (Clear)
		((shot.up_n == ROW_EMPTY) || $onehot(~shot.up_n)) &&
		((shot.down_n == ROW_EMPTY) || $onehot(~shot.down_n)))
		else $error("player_shot: bad bullet rows up %b down %b", shot.up_n, shot.down_n);

endmodule

`default_nettype wire

//--- design/referee.sv
`timescale 1ns/10ps
`default_nettype none

module referee #(
	parameter int unsigned TICK_DIV = 1500000
) (
	input wire CLK,
	input wire Clear,
	input wire duel_pkg::pos_t a_pos,
	input wire duel_pkg::pos_t b_pos,
	input wire duel_pkg::shot_t a_shot,
	input wire duel_pkg::shot_t b_shot,
	output logic game_tick,
	output logic game_over,
	output duel_pkg::life_t a_life,
	output duel_pkg::life_t b_life
);

	import duel_pkg::*;

	localparam int CW = (TICK_DIV > 2) ? $clog2(TICK_DIV) : 1;

	logic [CW-1:0] tick_cnt;
	logic a_hit;	// B's bullet on an unguarded A
	logic b_hit;

	// tick goes high in the cycle after the counter reaches TICK_DIV-2
	always_ff @(posedge CLK or posedge Clear)
	begin
		if (Clear)
		begin
			tick_cnt <= '0;
			game_tick <= 1'b0;
		end
		else
		begin
			if (tick_cnt == CW'(TICK_DIV - 1))
				tick_cnt <= '0;
			else
				tick_cnt <= tick_cnt + CW'(1);
			game_tick <= (tick_cnt == CW'(TICK_DIV - 2));
		end
	end

	// empty bullets are all ones and can never match a marker row
	assign a_hit = !a_pos.guard && (b_shot.col == a_pos.col) &&
		((b_shot.up_n == a_pos.row) || (b_shot.down_n == a_pos.row));
	assign b_hit = !b_pos.guard && (a_shot.col == b_pos.col) &&
		((a_shot.up_n == b_pos.row) || (a_shot.down_n == b_pos.row));

	always_ff @(posedge CLK or posedge Clear)
	begin
		if (Clear)
		begin
			a_life <= LIFE_FULL;
			b_life <= LIFE_FULL;
			game_over <= 1'b0;
		end
		else
		begin
			if (game_tick && !game_over)
			begin
				if (a_hit)
					a_life <= a_life >> 1;	// both bullets together still count once
				if (b_hit)
					b_life <= b_life >> 1;
			end
			if ((a_life == life_t'(0)) || (b_life == life_t'(0)))
				game_over <= 1'b1;
		end
	end

	property p_life_step(life_t life);
		@(posedge CLK) disable iff (Clear)
		(life == $past(life)) || (life == ($past(life) >> 1));
	endproperty

	a_a_life_step: assert property (p_life_step(a_life))
		else $error("referee: a_life went from %b to %b", $past(a_life), a_life);
	a_b_life_step: assert property (p_life_step(b_life))
		else $error("referee: b_life went from %b to %b", $past(b_life), b_life);

endmodule

`default_nettype wire

//--- design/matrix_scan.sv
`timescale 1ns/10ps
`default_nettype none

module matrix_scan (
	input wire CLK,
	input wire Clear,
	input wire duel_pkg::pos_t a_pos,
	input wire duel_pkg::pos_t b_pos,
	input wire duel_pkg::shot_t a_shot,
	input wire duel_pkg::shot_t b_shot,
	output duel_pkg::col_t column,
	output duel_pkg::row_t red_n,
	output duel_pkg::row_t green_n,
	output duel_pkg::row_t blue_n
);

	import duel_pkg::*;

	typedef enum logic [2:0] {
		S_A_POS,
		S_B_POS,
		S_A_UP,
		S_A_DOWN,
		S_B_UP,
		S_B_DOWN
	} slot_t;

	slot_t slot;
	col_t col_nxt;
	row_t red_nxt;
	row_t green_nxt;
	row_t blue_nxt;

	always_ff @(posedge CLK or posedge Clear)
	begin
		if (Clear)
			slot <= S_A_POS;
		else if (slot == slot_t'(SCAN_SLOTS - 1))
			slot <= S_A_POS;
		else
			slot <= slot_t'(slot + 3'd1);
	end

	always_comb
	begin
		col_nxt = a_pos.col;
		red_nxt = ROW_EMPTY;
		green_nxt = ROW_EMPTY;
		blue_nxt = ROW_EMPTY;
		case (slot)
			S_A_POS:
			begin
				red_nxt = a_pos.row;
				if (a_pos.guard)	// white
				begin
					green_nxt = a_pos.row;
					blue_nxt = a_pos.row;
				end
			end
			S_B_POS:
			begin
				col_nxt = b_pos.col;
				green_nxt = b_pos.row;
				if (b_pos.guard)
				begin
					red_nxt = b_pos.row;
					blue_nxt = b_pos.row;
				end
			end
			S_A_UP:
			begin
				col_nxt = a_shot.col;
				blue_nxt = a_shot.up_n;
			end
			S_A_DOWN:
			begin
				col_nxt = a_shot.col;
				blue_nxt = a_shot.down_n;
			end
			S_B_UP:
			begin
				col_nxt = b_shot.col;	// cyan
				green_nxt = b_shot.up_n;
				blue_nxt = b_shot.up_n;
			end
			S_B_DOWN:
			begin
				col_nxt = b_shot.col;
				green_nxt = b_shot.down_n;
				blue_nxt = b_shot.down_n;
			end
		endcase
	end

	always_ff @(posedge CLK or posedge Clear)
	begin
		if (Clear)
		begin
			column <= col_t'(0);
			red_n <= ROW_EMPTY;
			green_n <= ROW_EMPTY;
			blue_n <= ROW_EMPTY;
		end
		else
		begin
			column <= col_nxt;
			red_n <= red_nxt;
			green_n <= green_nxt;
			blue_n <= blue_nxt;
		end
	end

endmodule

`default_nettype wire

//--- design/duel_top.sv
`timescale 1ns/10ps
`default_nettype none

module duel_top #(
	parameter int unsigned TICK_DIV = 1500000,
	parameter duel_pkg::ammo_t AMMO_INIT = 4'd9
) (
	input wire CLK,
	input wire Clear,
	input wire duel_pkg::btn_t a_btn,
	input wire duel_pkg::btn_t b_btn,
	output duel_pkg::col_t column,
	output duel_pkg::row_t red_n,
	output duel_pkg::row_t green_n,
	output duel_pkg::row_t blue_n,
	output duel_pkg::life_t a_life,
	output duel_pkg::life_t b_life,
	output duel_pkg::ammo_t a_ammo,
	output duel_pkg::ammo_t b_ammo
);

	import duel_pkg::*;

	logic game_tick;
	logic game_over;
	pos_t a_pos;
	pos_t b_pos;
	shot_t a_shot;
	shot_t b_shot;

	player_move #(.START(A_START)) a_move (
		.CLK(CLK), .Clear(Clear), .game_tick(game_tick), .game_over(game_over),
		.btn(a_btn), .pos(a_pos)
	);

	player_move #(.START(B_START)) b_move (
		.CLK(CLK), .Clear(Clear), .game_tick(game_tick), .game_over(game_over),
		.btn(b_btn), .pos(b_pos)
	);

	player_shot #(.AMMO_INIT(AMMO_INIT)) a_gun (
		.CLK(CLK), .Clear(Clear), .game_tick(game_tick), .game_over(game_over),
		.fire(a_btn.fire), .pos(a_pos), .shot(a_shot), .ammo(a_ammo)
	);

	player_shot #(.AMMO_INIT(AMMO_INIT)) b_gun (
		.CLK(CLK), .Clear(Clear), .game_tick(game_tick), .game_over(game_over),
		.fire(b_btn.fire), .pos(b_pos), .shot(b_shot), .ammo(b_ammo)
	);

	referee #(.TICK_DIV(TICK_DIV)) ref0 (
		.CLK(CLK), .Clear(Clear),
		.a_pos(a_pos), .b_pos(b_pos), .a_shot(a_shot), .b_shot(b_shot),
		.game_tick(game_tick), .game_over(game_over),
		.a_life(a_life), .b_life(b_life)
	);

	matrix_scan scan0 (
		.CLK(CLK), .Clear(Clear),
		.a_pos(a_pos), .b_pos(b_pos), .a_shot(a_shot), .b_shot(b_shot),
		.column(column), .red_n(red_n), .green_n(green_n), .blue_n(blue_n)
	);

endmodule

`default_nettype wire

//--- verification/duel_tb.sv
`timescale 1ns/10ps
`default_nettype none

module duel_tb;

	import duel_pkg::*;

	localparam int TICK_DIV = 8;
	localparam ammo_t AMMO_INIT = 4'd3;
	localparam int WATCH_TICKS = 400;

	localparam btn_t IDLE = 6'b000000;
	localparam btn_t UP = 6'b100000;
	localparam btn_t DOWN = 6'b010000;
	localparam btn_t LEFT = 6'b001000;
	localparam btn_t RIGHT = 6'b000100;
	localparam btn_t FIRE = 6'b000010;
	localparam btn_t GUARD = 6'b000001;

	logic CLK;
	logic Clear;
	btn_t a_btn;
	btn_t b_btn;
	col_t column;
	row_t red_n;
	row_t green_n;
	row_t blue_n;
	life_t a_life;
	life_t b_life;
	ammo_t a_ammo;
	ammo_t b_ammo;

	// model state per player with A at index 0 and -1 for no bullet
	int m_row[2];
	int m_col[2];
	logic m_guard[2];
	int m_up[2];
	int m_dn[2];
	int m_scol[2];
	ammo_t m_ammo[2];
	life_t m_life[2];
	logic m_tick;
	logic m_over;
	int edge_n;	// edges since Clear fell
	int m_slot;
	int shown_slot;
	col_t exp_col;
	row_t exp_r;
	row_t exp_g;
	row_t exp_b;

	integer seed;
	string test_name;
	int scan_errors;
	int port_errors;
	int status_errors;

	duel_top #(.TICK_DIV(TICK_DIV), .AMMO_INIT(AMMO_INIT)) dut0 (.*);

	always #2 CLK = ~CLK;

	function automatic row_t row_mask(input int r);
		if (r < 0)
			return ROW_EMPTY;
		return ~(row_t'(1) << r);
	endfunction

	// one game tick of player p against the other player
	task step_player(input int p);
		btn_t bt;
		int q;
		bt = (p == 0) ? a_btn : b_btn;
		q = 1 - p;
		if (bt.up)
		begin
			if (m_row[p] > 0)
				m_row[p] <= m_row[p] - 1;
		end
		else if (bt.down && m_row[p] < 7)
			m_row[p] <= m_row[p] + 1;
		if (bt.left)
		begin
			if (m_col[p] > 0)
				m_col[p] <= m_col[p] - 1;
		end
		else if (bt.right && m_col[p] < 7)
			m_col[p] <= m_col[p] + 1;
		m_guard[p] <= bt.guard;
		if (m_up[p] < 0 && m_dn[p] < 0 && bt.fire && m_ammo[p] != 0)
		begin
			m_up[p] <= m_row[p] - 1;	// off the top gives -1
			m_dn[p] <= (m_row[p] == 7) ? -1 : m_row[p] + 1;
			m_scol[p] <= m_col[p];
			m_ammo[p] <= m_ammo[p] - 1;
		end
		else
		begin
			m_up[p] <= (m_up[p] < 0) ? -1 : m_up[p] - 1;
			m_dn[p] <= (m_dn[p] < 0 || m_dn[p] == 7) ? -1 : m_dn[p] + 1;
		end
		if (!m_guard[p] && m_scol[q] == m_col[p] &&
			(m_up[q] == m_row[p] || m_dn[q] == m_row[p]))
			m_life[p] <= m_life[p] >> 1;
	endtask

	// expected colours and column for the current scan slot
	task show_slot();
		int p;
		row_t m;
		p = (m_slot == 1 || m_slot >= 4) ? 1 : 0;
		exp_r <= ROW_EMPTY;
		exp_g <= ROW_EMPTY;
		exp_b <= ROW_EMPTY;
		if (m_slot < 2)
		begin
			m = row_mask(m_row[p]);
			exp_col <= col_t'(m_col[p]);
			if (p == 0)
				exp_r <= m;
			else
				exp_g <= m;
			if (m_guard[p])	// white
			begin
				exp_r <= m;
				exp_g <= m;
				exp_b <= m;
			end
		end
		else
		begin
			m = row_mask((m_slot % 2 == 0) ? m_up[p] : m_dn[p]);
			exp_col <= col_t'(m_scol[p]);
			exp_b <= m;
			if (p == 1)
				exp_g <= m;	// cyan for B
		end
	endtask

	always @(posedge CLK or posedge Clear)
	begin
		if (Clear)
		begin
			edge_n <= 0;
			m_tick <= 1'b0;
			m_over <= 1'b0;
			m_slot <= 0;
			shown_slot <= 0;
			exp_col <= col_t'(0);
			exp_r <= ROW_EMPTY;
			exp_g <= ROW_EMPTY;
			exp_b <= ROW_EMPTY;
			for (int p = 0; p < 2; p++)
			begin
				m_row[p] <= (p == 0) ? 7 : 0;
				m_col[p] <= 4;
				m_guard[p] <= 1'b0;
				m_up[p] <= -1;
				m_dn[p] <= -1;
				m_scol[p] <= 0;
				m_ammo[p] <= AMMO_INIT;
				m_life[p] <= LIFE_FULL;
			end
		end
		else
		begin
			edge_n <= edge_n + 1;
			m_tick <= ((edge_n + 2) % TICK_DIV) == 0;	// high before each tick edge
			if (m_life[0] == 0 || m_life[1] == 0)
				m_over <= 1'b1;
			if (((edge_n + 1) % TICK_DIV) == 0 && !m_over)
				for (int p = 0; p < 2; p++)
					step_player(p);
			show_slot();
			shown_slot <= m_slot;
			m_slot <= (m_slot + 1) % SCAN_SLOTS;
		end
	end

	scan_match: assert property (@(negedge CLK) disable iff (Clear)
		column == exp_col && red_n == exp_r && green_n == exp_g && blue_n == exp_b)
	else
	begin
		scan_errors++;
		$display("Mismatch in %s: slot %0d expected %0d %b %b %b, actual %0d %b %b %b",
			test_name, shown_slot, exp_col, exp_r, exp_g, exp_b,
			column, red_n, green_n, blue_n);
	end

	life_match: assert property (@(posedge CLK) disable iff (Clear)
		a_life == m_life[0] && b_life == m_life[1])
	else
	begin
		port_errors++;
		$display("Mismatch in %s: lives expected %0d %0d, actual %0d %0d", test_name,
			$sampled(m_life[0]), $sampled(m_life[1]), $sampled(a_life), $sampled(b_life));
	end

	ammo_match: assert property (@(posedge CLK) disable iff (Clear)
		a_ammo == m_ammo[0] && b_ammo == m_ammo[1])
	else
	begin
		port_errors++;
		$display("Mismatch in %s: ammo expected %0d %0d, actual %0d %0d", test_name,
			$sampled(m_ammo[0]), $sampled(m_ammo[1]), $sampled(a_ammo), $sampled(b_ammo));
	end

	tick_match: assert property (@(posedge CLK) disable iff (Clear)
		dut0.game_tick == m_tick && dut0.game_over == m_over)
	else
	begin
		status_errors++;
		$display("Mismatch in %s: tick and game over expected %b %b, actual %b %b", test_name,
			$sampled(m_tick), $sampled(m_over),
			$sampled(dut0.game_tick), $sampled(dut0.game_over));
	end

	task clear_game();
		@(posedge CLK);
		Clear <= 1'b1;
		repeat (3) @(posedge CLK);
		Clear <= 1'b0;
	endtask

	// each call holds the buttons across whole ticks
	task drive(input btn_t a, input btn_t b, input int ticks);
		a_btn <= a;
		b_btn <= b;
		repeat (ticks * TICK_DIV) @(posedge CLK);
	endtask

	task random_buttons(input int ticks);
		int r;
		repeat (ticks)
		begin
			r = $random(seed);
			drive(btn_t'(r[5:0]), btn_t'(r[13:8]), 1);
		end
	endtask

	initial
	begin
		#(WATCH_TICKS * TICK_DIV * 4);
		$display("watchdog: no end after %0d ticks, errors scan %0d ports %0d status %0d",
			WATCH_TICKS, scan_errors, port_errors, status_errors);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial
	begin
		CLK = 1'b0;
		Clear = 1'b1;
		a_btn = IDLE;
		b_btn = IDLE;
		seed = 32'h691;
		scan_errors = 0;
		port_errors = 0;
		status_errors = 0;
		test_name = "reset";
		clear_game();
		drive(IDLE, IDLE, 2);

		test_name = "movement";
		drive(LEFT | RIGHT, UP, 5);	// A to col 0, B held at the top
		drive(RIGHT, RIGHT, 9);
		drive(UP | DOWN, DOWN, 3);
		drive(DOWN, UP, 5);	// A row 7, B row 0, both col 7

		test_name = "shooting";
		drive(FIRE, IDLE, 1);
		drive(FIRE, IDLE, 3);	// bullet still on the matrix
		drive(IDLE, IDLE, 5);	// hits B at the top

		test_name = "guarded hit";
		drive(FIRE, GUARD, 1);
		drive(IDLE, GUARD, 8);

		test_name = "empty ammo";
		drive(FIRE, IDLE, 1);
		drive(IDLE, IDLE, 8);
		drive(FIRE, IDLE, 3);

		test_name = "hit on A";
		drive(IDLE, FIRE, 1);
		drive(IDLE, IDLE, 8);

		test_name = "random";
		clear_game();	// full ammo for both players
		random_buttons(120);

		test_name = "game over";
		clear_game();
		drive(IDLE, DOWN, 6);	// B right above A
		drive(FIRE, IDLE, 1);
		drive(IDLE, UP, 6);	// B runs with the bullet and takes a hit each tick
		random_buttons(20);

		$display("errors: scan %0d, life and ammo %0d, tick and game over %0d",
			scan_errors, port_errors, status_errors);
		if (scan_errors + port_errors + status_errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
common/duel_pkg.sv
player/player_move.sv
player/player_shot.sv
design/referee.sv
design/matrix_scan.sv
design/duel_top.sv
verification/duel_tb.sv
